// ==== hdl/matmul_pkg.sv ====
`default_nettype none

package matmul_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int DWIDTH     = 8;
  localparam int MAT_SIZE   = 4;
  localparam int AWIDTH     = 11;
  localparam int MEM_BYTES  = 2048;
  localparam int REG_DWIDTH = 32;
  localparam int REG_AWIDTH = 8;
  localparam int IDX_W      = 2;

  ////////////////////////////////////////
  // Data types
  ////////////////////////////////////////

  typedef logic [DWIDTH-1:0] elem_t;

  // Element i of a row sits at byte address base+i
  typedef elem_t [MAT_SIZE-1:0] row_t;

  typedef logic [AWIDTH-1:0] addr_t;

  typedef struct packed {
    addr_t               addr;
    row_t                wdata;
    logic [MAT_SIZE-1:0] we;
  } mem_req_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [REG_AWIDTH-1:0] paddr;
    logic [REG_DWIDTH-1:0] pwdata;
  } apb_req_t;

  // Base addresses of the three operands
  typedef struct packed {
    addr_t addr_a;
    addr_t addr_b;
    addr_t addr_c;
  } mm_cfg_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  typedef enum logic [REG_AWIDTH-1:0] {
    REG_START_DONE = 8'h00,
    REG_MATRIX_A   = 8'h0E,
    REG_MATRIX_B   = 8'h12,
    REG_MATRIX_C   = 8'h16
  } reg_addr_e;

  // Any other value selects no bank
  typedef enum logic [7:0] {
    BANK_A = 8'd0,
    BANK_B = 8'd1,
    BANK_C = 8'd2
  } bank_sel_e;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_W_ENABLE,
    APB_R_ENABLE
  } apb_state_e;

  typedef enum logic [2:0] {
    CS_IDLE,
    CS_LOAD,
    CS_LAST,
    CS_WRITE,
    CS_DONE
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== hdl/byte_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_ram (
  input  logic                 clk,
  input  matmul_pkg::mem_req_t p0,
  output matmul_pkg::row_t     q0,
  input  matmul_pkg::mem_req_t p1,
  output matmul_pkg::row_t     q1
);
  import matmul_pkg::*;

  elem_t mem [MEM_BYTES];

  // Port 0 writes last so it wins a shared byte
  always_ff @(posedge clk) begin
    for (int i = 0; i < MAT_SIZE; i++) begin
      if (p1.we[i]) begin
        mem[p1.addr + addr_t'(i)] <= p1.wdata[i];
      end
      if (p0.we[i]) begin
        mem[p0.addr + addr_t'(i)] <= p0.wdata[i];
      end
    end
  end

  // Registered word reads, old data on a same-cycle write
  always_ff @(posedge clk) begin
    for (int i = 0; i < MAT_SIZE; i++) begin
      q0[i] <= mem[p0.addr + addr_t'(i)];
      q1[i] <= mem[p1.addr + addr_t'(i)];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mac_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_array (
  input  logic                         clk,
  input  logic                         PRESETn,
  input  logic                         acc_clear,
  input  logic                         acc_en,
  input  matmul_pkg::row_t             a_col,
  input  matmul_pkg::row_t             b_row,
  input  logic [matmul_pkg::IDX_W-1:0] row_sel,
  output matmul_pkg::row_t             c_row
);
  import matmul_pkg::*;

  // acc[i][j] holds element (i, j) of the product
  row_t acc [MAT_SIZE];

  ////////////////////////////////////////
  // Outer-product accumulate
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!PRESETn || acc_clear) begin
      for (int i = 0; i < MAT_SIZE; i++) begin
        acc[i] <= '0;
      end
    end else if (acc_en) begin
      for (int i = 0; i < MAT_SIZE; i++) begin
        for (int j = 0; j < MAT_SIZE; j++) begin
          // 8-bit result, wraps modulo 256
          acc[i][j] <= acc[i][j] + a_col[i] * b_row[j];
        end
      end
    end
  end

  // Row readout for the C bank
  assign c_row = acc[row_sel];

endmodule

`default_nettype wire

// ==== hdl/host_mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_mem_port (
  input  logic                  clk,
  input  logic                  PRESETn,
  input  matmul_pkg::bank_sel_e bram_select,
  input  matmul_pkg::mem_req_t  host,
  input  matmul_pkg::row_t      q_a,
  input  matmul_pkg::row_t      q_b,
  input  matmul_pkg::row_t      q_c,
  output matmul_pkg::mem_req_t  p1_a,
  output matmul_pkg::mem_req_t  p1_b,
  output matmul_pkg::mem_req_t  p1_c,
  output matmul_pkg::row_t      host_rdata
);
  import matmul_pkg::*;

  mem_req_t  idle_req;
  bank_sel_e sel_q;

  // Same address and data everywhere, strobes only on the chosen bank
  assign idle_req = '{addr: host.addr, wdata: host.wdata, we: '0};

  assign p1_a = (bram_select == BANK_A) ? host : idle_req;
  assign p1_b = (bram_select == BANK_B) ? host : idle_req;
  assign p1_c = (bram_select == BANK_C) ? host : idle_req;

  // Select follows the bank read latency
  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      sel_q <= bank_sel_e'(8'hFF);
    end else begin
      sel_q <= bram_select;
    end
  end

  always_comb begin
    case (sel_q)
      BANK_A:  host_rdata = q_a;
      BANK_B:  host_rdata = q_b;
      BANK_C:  host_rdata = q_c;
      default: host_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_regs (
  input  logic                              clk,
  input  logic                              PRESETn,
  input  matmul_pkg::apb_req_t              apb,
  output logic [matmul_pkg::REG_DWIDTH-1:0] prdata,
  output logic                              pready,
  input  logic                              busy,
  input  logic                              done,
  output matmul_pkg::mm_cfg_t               cfg,
  output logic                              start,
  output logic                              clear_done
);
  import matmul_pkg::*;

  localparam int PAD_W = REG_DWIDTH - AWIDTH;

  apb_state_e            state;
  logic                  wr_fire;
  logic                  rd_fire;
  logic                  mapped;
  logic [REG_DWIDTH-1:0] dummy;
  logic [REG_DWIDTH-1:0] rd_word;

  // Access phase of a transfer that began with a proper setup
  assign wr_fire = (state == APB_W_ENABLE) && apb.psel && apb.pwrite && apb.penable;
  assign rd_fire = (state == APB_R_ENABLE) && apb.psel && !apb.pwrite && apb.penable;

  ////////////////////////////////////////
  // Offset decode and read mux
  ////////////////////////////////////////

  always_comb begin
    mapped  = 1'b1;
    rd_word = dummy;
    case (apb.paddr)
      REG_START_DONE: rd_word = {done, {(REG_DWIDTH-2){1'b0}}, busy};
      REG_MATRIX_A:   rd_word = {{PAD_W{1'b0}}, cfg.addr_a};
      REG_MATRIX_B:   rd_word = {{PAD_W{1'b0}}, cfg.addr_b};
      REG_MATRIX_C:   rd_word = {{PAD_W{1'b0}}, cfg.addr_c};
      default:        mapped  = 1'b0;
    endcase
  end

  // Unmapped offsets all share one scratch word
  always_ff @(posedge clk) begin
    if (wr_fire && !mapped) begin
      dummy <= apb.pwdata;
    end
  end

  ////////////////////////////////////////
  // APB FSM and registers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state      <= APB_IDLE;
      prdata     <= '0;
      pready     <= 1'b0;
      cfg        <= '0;
      start      <= 1'b0;
      clear_done <= 1'b0;
    end else begin
      // Pulses last one cycle
      start      <= 1'b0;
      clear_done <= 1'b0;
      pready     <= 1'b0;
      case (state)
        APB_IDLE: begin
          prdata <= '0;
          // Only a setup phase opens a transfer
          if (apb.psel && !apb.penable) begin
            state <= apb.pwrite ? APB_W_ENABLE : APB_R_ENABLE;
          end
        end
        APB_W_ENABLE: begin
          if (wr_fire) begin
            pready <= 1'b1;
            case (apb.paddr)
              REG_START_DONE: begin
                start      <= apb.pwdata[0];
                clear_done <= apb.pwdata[REG_DWIDTH-1];
              end
              REG_MATRIX_A: cfg.addr_a <= apb.pwdata[AWIDTH-1:0];
              REG_MATRIX_B: cfg.addr_b <= apb.pwdata[AWIDTH-1:0];
              REG_MATRIX_C: cfg.addr_c <= apb.pwdata[AWIDTH-1:0];
              default: ;
            endcase
          end
          state <= APB_IDLE;
        end
        APB_R_ENABLE: begin
          if (rd_fire) begin
            pready <= 1'b1;
            prdata <= rd_word;
          end
          state <= APB_IDLE;
        end
        default: state <= APB_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/matmul_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_ctrl (
  input  logic                         clk,
  input  logic                         PRESETn,
  input  logic                         start,
  input  logic                         clear_done,
  input  matmul_pkg::mm_cfg_t          cfg,
  output logic                         busy,
  output logic                         done,
  output matmul_pkg::mem_req_t         a_req,
  output matmul_pkg::mem_req_t         b_req,
  output matmul_pkg::mem_req_t         c_req,
  output logic                         acc_clear,
  output logic                         acc_en,
  output logic [matmul_pkg::IDX_W-1:0] row_sel
);
  import matmul_pkg::*;

  ctrl_state_e      state;
  ctrl_state_e      state_nxt;
  logic [IDX_W-1:0] idx;
  addr_t            offset;

  ////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      CS_IDLE:  if (start) state_nxt = CS_LOAD;
      CS_LOAD:  if (idx == IDX_W'(MAT_SIZE - 1)) state_nxt = CS_LAST;
      CS_LAST:  state_nxt = CS_WRITE;
      CS_WRITE: if (idx == IDX_W'(MAT_SIZE - 1)) state_nxt = CS_DONE;
      CS_DONE:  if (clear_done) state_nxt = CS_IDLE;
      default:  state_nxt = CS_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!PRESETn) begin
      state  <= CS_IDLE;
      idx    <= '0;
      acc_en <= 1'b0;
    end else begin
      state <= state_nxt;
      // Step index in LOAD, row index in WRITE
      if (state == CS_LOAD || state == CS_WRITE) begin
        idx <= idx + 1'b1;
      end else begin
        idx <= '0;
      end
      // Bank data arrives one cycle after the read
      acc_en <= (state == CS_LOAD);
    end
  end

  assign busy      = (state == CS_LOAD) || (state == CS_LAST) || (state == CS_WRITE);
  assign done      = (state == CS_DONE);
  assign acc_clear = (state == CS_LOAD) && (idx == '0);
  assign row_sel   = idx;

  ////////////////////////////////////////
  // Bank requests
  ////////////////////////////////////////

  // Rows and columns are packed 4 bytes apart
  assign offset = addr_t'({idx, 2'b00});

  assign a_req = '{addr: cfg.addr_a + offset, wdata: '0, we: '0};
  assign b_req = '{addr: cfg.addr_b + offset, wdata: '0, we: '0};

  // Row data is taken from the array where the C bank is wired up
  assign c_req.addr  = cfg.addr_c + offset;
  assign c_req.wdata = '0;
  assign c_req.we    = (state == CS_WRITE) ? '1 : '0;

endmodule

`default_nettype wire

// ==== hdl/matmul_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_top (
  input  logic                              clk,
  input  logic                              PRESETn,
  input  matmul_pkg::apb_req_t              apb,
  output logic [matmul_pkg::REG_DWIDTH-1:0] prdata,
  output logic                              pready,
  input  matmul_pkg::bank_sel_e             bram_select,
  input  matmul_pkg::mem_req_t              host,
  output matmul_pkg::row_t                  host_rdata
);
  import matmul_pkg::*;

  mm_cfg_t          cfg;
  logic             busy;
  logic             done;
  logic             start;
  logic             clear_done;
  mem_req_t         a_req;
  mem_req_t         b_req;
  mem_req_t         c_req;
  mem_req_t         c_wr;
  logic             acc_clear;
  logic             acc_en;
  logic [IDX_W-1:0] row_sel;
  row_t             a_col;
  row_t             b_row;
  row_t             c_row;
  mem_req_t         p1_a;
  mem_req_t         p1_b;
  mem_req_t         p1_c;
  row_t             q_a;
  row_t             q_b;
  row_t             q_c;

  ////////////////////////////////////////
  // Register block and sequencer
  ////////////////////////////////////////

  apb_regs u_apb_regs (
    .clk, .PRESETn, .apb, .prdata, .pready,
    .busy, .done, .cfg, .start, .clear_done
  );

  matmul_ctrl u_matmul_ctrl (
    .clk, .PRESETn, .start, .clear_done, .cfg, .busy, .done,
    .a_req, .b_req, .c_req, .acc_clear, .acc_en, .row_sel
  );

  mac_array u_mac_array (
    .clk, .PRESETn, .acc_clear, .acc_en, .a_col, .b_row, .row_sel, .c_row
  );

  // C rows come from the array, address and strobes from the sequencer
  assign c_wr = '{addr: c_req.addr, wdata: c_row, we: c_req.we};

  ////////////////////////////////////////
  // Operand and result banks
  ////////////////////////////////////////

  host_mem_port u_host_mem_port (
    .clk, .PRESETn, .bram_select, .host,
    .q_a, .q_b, .q_c, .p1_a, .p1_b, .p1_c, .host_rdata
  );

  byte_ram bank_a (.clk, .p0(a_req), .q0(a_col), .p1(p1_a), .q1(q_a));
  byte_ram bank_b (.clk, .p0(b_req), .q0(b_row), .p1(p1_b), .q1(q_b));

  // Port 0 of C only writes
  byte_ram bank_c (.clk, .p0(c_wr), .q0(), .p1(p1_c), .q1(q_c));

endmodule

`default_nettype wire

// ==== dv/tb_matmul.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_matmul;
  import matmul_pkg::*;

  // A full pass takes a few hundred cycles, so 5000 leaves wide margin
  localparam int MAX_CYCLES = 5000;
  localparam int MAX_POLLS  = 40;

  logic                  clk;
  logic                  PRESETn;
  apb_req_t              apb;
  logic [REG_DWIDTH-1:0] prdata;
  logic                  pready;
  bank_sel_e             bram_select;
  mem_req_t              host;
  row_t                  host_rdata;

  elem_t mat_a [MAT_SIZE][MAT_SIZE];
  elem_t mat_b [MAT_SIZE][MAT_SIZE];
  elem_t exp_c [MAT_SIZE][MAT_SIZE];
  addr_t base_a;
  addr_t base_b;
  addr_t base_c;
  int    cycles = 0;
  int    errors;
  int    err_mark;
  int    tests_run;
  int    tests_failed;

  matmul_top dut0 (
    .clk, .PRESETn, .apb, .prdata, .pready, .bram_select, .host, .host_rdata
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Checking and reporting
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] got);
    assert (got === exp_val) else begin
      $display("** Error at %0d ns: %s expected 0x%08h, got 0x%08h",
               $time, name, exp_val, got);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s: pass", name);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  ////////////////////////////////////////
  // Bus and host port drivers
  ////////////////////////////////////////

  // pready is due on the first falling edge after the access phase
  task automatic wait_ready();
    int waits;
    waits = 0;
    do begin
      @(negedge clk);
      waits++;
    end while (!pready);
    check_value("pready delay in cycles", 32'd1, 32'(waits));
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    // pready of the last transfer lasted one cycle
    check_value("pready before setup", 32'h0, {31'b0, pready});
    apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(negedge clk);
    apb.penable = 1'b1;
    wait_ready();
    apb = '0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(negedge clk);
    check_value("pready before setup", 32'h0, {31'b0, pready});
    apb = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
    @(negedge clk);
    apb.penable = 1'b1;
    wait_ready();
    data = prdata;
    apb = '0;
  endtask

  task automatic host_write(input bank_sel_e sel, input addr_t addr, input row_t data,
                            input logic [3:0] mask);
    @(negedge clk);
    bram_select = sel;
    host = '{addr: addr, wdata: data, we: mask};
    @(negedge clk);
    host.we = '0;
  endtask

  // Read data shows up one cycle after the address
  task automatic host_read(input bank_sel_e sel, input addr_t addr, output row_t data);
    @(negedge clk);
    bram_select = sel;
    host = '{addr: addr, wdata: '0, we: '0};
    @(negedge clk);
    data = host_rdata;
  endtask

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic void fill_operands(input bit new_a, input bit new_b);
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        if (new_a) mat_a[i][j] = elem_t'($urandom);
        if (new_b) mat_b[i][j] = elem_t'($urandom);
      end
    end
  endfunction

  // C = A x B, every element wraps to 8 bits
  function automatic void compute_model();
    int sum;
    for (int i = 0; i < MAT_SIZE; i++) begin
      for (int j = 0; j < MAT_SIZE; j++) begin
        sum = 0;
        for (int k = 0; k < MAT_SIZE; k++) begin
          sum += int'(mat_a[i][k]) * int'(mat_b[k][j]);
        end
        exp_c[i][j] = elem_t'(sum);
      end
    end
  endfunction

  // A is stored column by column
  function automatic row_t col_of_a(input int k);
    row_t r;
    for (int i = 0; i < MAT_SIZE; i++) r[i] = mat_a[i][k];
    return r;
  endfunction

  function automatic row_t row_of_b(input int k);
    row_t r;
    for (int j = 0; j < MAT_SIZE; j++) r[j] = mat_b[k][j];
    return r;
  endfunction

  function automatic row_t row_of_c(input int i);
    row_t r;
    for (int j = 0; j < MAT_SIZE; j++) r[j] = exp_c[i][j];
    return r;
  endfunction

  ////////////////////////////////////////
  // Run helpers
  ////////////////////////////////////////

  task automatic load_a();
    for (int k = 0; k < MAT_SIZE; k++) begin
      host_write(BANK_A, base_a + addr_t'(4 * k), col_of_a(k), 4'hF);
    end
  endtask

  task automatic load_b();
    for (int k = 0; k < MAT_SIZE; k++) begin
      host_write(BANK_B, base_b + addr_t'(4 * k), row_of_b(k), 4'hF);
    end
  endtask

  task automatic run_and_wait();
    logic [31:0] status;
    int          polls;
    apb_write(REG_START_DONE, 32'h1);
    polls  = 0;
    status = '0;
    while (!status[31] && polls < MAX_POLLS) begin
      apb_read(REG_START_DONE, status);
      // Between start and done the sequencer is always busy
      check_value("prdata status while running",
                  status[31] ? 32'h8000_0000 : 32'h1, status);
      polls++;
    end
    if (!status[31]) begin
      $display("Error at %0d ns: done bit still clear after %0d status reads",
               $time, MAX_POLLS);
      errors++;
    end
  endtask

  task automatic check_c(input string tag);
    row_t got;
    for (int i = 0; i < MAT_SIZE; i++) begin
      host_read(BANK_C, base_c + addr_t'(4 * i), got);
      check_value($sformatf("host_rdata C row %0d (%s)", i, tag), row_of_c(i), got);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_registers();
    logic [31:0] rd;
    logic [31:0] val;
    logic [7:0]  off;
    apb_read(REG_START_DONE, rd);
    check_value("prdata status after reset", 32'h0, rd);
    for (int r = 0; r < 3; r++) begin
      off = 8'(14 + 4 * r);
      apb_read(off, rd);
      check_value($sformatf("prdata base 0x%02h after reset", off), 32'h0, rd);
      // Only the low 11 bits are kept
      val = $urandom;
      apb_write(off, val);
      apb_read(off, rd);
      check_value($sformatf("prdata base 0x%02h", off), {21'b0, val[10:0]}, rd);
    end
    val = $urandom;
    apb_write(8'h40, val);
    apb_read(8'hF0, rd);
    check_value("prdata unmapped 0xF0", val, rd);
  endtask

  task automatic test_host_memory();
    row_t        w0;
    row_t        w1;
    row_t        exp_w;
    row_t        got;
    addr_t       a;
    logic [3:0]  mask;
    for (int b = 0; b < 3; b++) begin
      a  = addr_t'($urandom_range(0, 511) * 4);
      w0 = row_t'($urandom);
      host_write(bank_sel_e'(8'(b)), a, w0, 4'hF);
      host_read(bank_sel_e'(8'(b)), a, got);
      check_value($sformatf("host_rdata bank %0d", b), w0, got);
    end
    // Partial mask merges into the old word
    a    = addr_t'($urandom_range(0, 511) * 4);
    w0   = row_t'($urandom);
    w1   = row_t'($urandom);
    mask = 4'b1010;
    host_write(BANK_B, a, w0, 4'hF);
    host_write(BANK_B, a, w1, mask);
    for (int i = 0; i < MAT_SIZE; i++) exp_w[i] = mask[i] ? w1[i] : w0[i];
    host_read(BANK_B, a, got);
    check_value("host_rdata byte mask", exp_w, got);
    // Invalid select neither writes nor returns data
    host_write(bank_sel_e'(8'h03), a, ~w0, 4'hF);
    host_read(bank_sel_e'(8'h03), a, got);
    check_value("host_rdata invalid select", 32'h0, got);
    host_read(BANK_B, a, got);
    check_value("host_rdata after invalid write", exp_w, got);
  endtask

  task automatic test_multiply();
    base_a = addr_t'($urandom_range(0, 124) * 4);
    base_b = addr_t'(512 + $urandom_range(0, 124) * 4);
    base_c = addr_t'(1024 + $urandom_range(0, 124) * 4);
    apb_write(REG_MATRIX_A, 32'(base_a));
    apb_write(REG_MATRIX_B, 32'(base_b));
    apb_write(REG_MATRIX_C, 32'(base_c));
    fill_operands(1'b1, 1'b1);
    load_a();
    load_b();
    compute_model();
    run_and_wait();
    check_c("first run");
  endtask

  task automatic test_operands_kept();
    row_t got;
    for (int k = 0; k < MAT_SIZE; k++) begin
      host_read(BANK_A, base_a + addr_t'(4 * k), got);
      check_value($sformatf("host_rdata A column %0d", k), col_of_a(k), got);
      host_read(BANK_B, base_b + addr_t'(4 * k), got);
      check_value($sformatf("host_rdata B row %0d", k), row_of_b(k), got);
    end
  endtask

  task automatic test_handshake();
    logic [31:0] rd;
    // New A, but the old C must survive an ignored start
    fill_operands(1'b1, 1'b0);
    load_a();
    apb_write(REG_START_DONE, 32'h1);
    repeat (12) @(negedge clk);
    apb_read(REG_START_DONE, rd);
    check_value("prdata status while done", 32'h8000_0000, rd);
    check_c("start while done");
    apb_write(REG_START_DONE, 32'h8000_0000);
    apb_read(REG_START_DONE, rd);
    check_value("prdata status after clear", 32'h0, rd);
    fill_operands(1'b0, 1'b1);
    load_b();
    compute_model();
    run_and_wait();
    check_c("second run");
  endtask

  initial begin
    void'($urandom(89607));
    PRESETn      = 1'b0;
    apb          = '0;
    bram_select  = BANK_A;
    host         = '0;
    errors       = 0;
    err_mark     = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    PRESETn = 1'b1;

    test_registers();
    finish_test("register access");
    test_host_memory();
    finish_test("host memory");
    test_multiply();
    finish_test("multiply");
    test_operands_kept();
    finish_test("operands preserved");
    test_handshake();
    finish_test("start/done handshake");

    $display("tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/matmul_pkg.sv
hdl/byte_ram.sv
hdl/mac_array.sv
hdl/host_mem_port.sv
hdl/apb_regs.sv
hdl/matmul_ctrl.sv
hdl/matmul_top.sv
dv/tb_matmul.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the matmul testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_matmul -f flist.f -o sim_matmul
./obj_dir/sim_matmul > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation passed"
